// File: rtl/addr_pkg.sv
package addr_pkg;

    localparam int VA_W  = 32;
    localparam int PA_W  = 32;
    localparam int REG_W = 32;    // mode word and window registers
    localparam int SEG_W = 3;     // window segment field

    // mode word fields
    localparam int CRMD_PLV_LO = 0;    // two-bit privilege level
    localparam int CRMD_DA_BIT = 3;    // direct address
    localparam int CRMD_PG_BIT = 4;    // paging enable

    // direct-mapped window register fields
    localparam int DMW_PLV0_BIT = 0;
    localparam int DMW_PLV3_BIT = 3;
    localparam int DMW_PSEG_LO  = 25;  // physical segment 27:25
    localparam int DMW_VSEG_LO  = 29;  // virtual segment 31:29

    // one virtual address seen by the TLB as pages and by the windows as segments
    typedef union packed {
        struct packed {
            logic [18:0] vppn;      // bits 31:13
            logic        odd;       // bit 12
            logic [11:0] offset;
        } page;
        struct packed {
            logic [SEG_W-1:0]      vseg;
            logic [VA_W-SEG_W-1:0] rest;
        } win;
    } va_t;

endpackage

// File: rtl/mmu_ifs.sv
interface tlb_write_if #(
    parameter int IDX_W = 4
);
    import tlb_pkg::*;

    logic              we;
    logic [IDX_W-1:0]  index;
    logic              e;
    logic [VPPN_W-1:0] vppn;
    logic [PS_W-1:0]   ps;
    logic [ASID_W-1:0] asid;
    logic              g;
    logic [PPN_W-1:0]  ppn0;     // even page
    logic [PLV_W-1:0]  plv0;
    logic              d0;
    logic              v0;
    logic [PPN_W-1:0]  ppn1;     // odd page
    logic [PLV_W-1:0]  plv1;
    logic              d1;
    logic              v1;

    modport source (output we, index, e, vppn, ps, asid, g,
                    ppn0, plv0, d0, v0, ppn1, plv1, d1, v1);
    modport sink   (input  we, index, e, vppn, ps, asid, g,
                    ppn0, plv0, d0, v0, ppn1, plv1, d1, v1);
endinterface

interface tlb_result_if;
    import addr_pkg::*;
    import tlb_pkg::*;

    logic             found;
    logic [PA_W-1:0]  pa;       // already formed for page size and odd/even
    logic [PLV_W-1:0] plv;
    logic             d;
    logic             v;

    modport source (output found, pa, plv, d, v);
    modport sink   (input  found, pa, plv, d, v);
endinterface

interface window_result_if;
    import addr_pkg::*;

    logic            hit;
    logic [PA_W-1:0] pa;

    modport source (output hit, pa);
    modport sink   (input  hit, pa);
endinterface

// File: rtl/mmu_top.sv
module mmu_top #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           req_valid,
    input  logic [addr_pkg::VA_W-1:0]      req_va,
    input  logic [tlb_pkg::KIND_W-1:0]     req_kind,
    input  logic [tlb_pkg::ASID_W-1:0]     req_asid,
    input  logic [addr_pkg::REG_W-1:0]     crmd,
    input  logic [addr_pkg::REG_W-1:0]     dmw0,
    input  logic [addr_pkg::REG_W-1:0]     dmw1,
    input  logic                           tlb_we,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_index,
    input  logic                           tlb_e,
    input  logic [tlb_pkg::VPPN_W-1:0]     tlb_vppn,
    input  logic [tlb_pkg::PS_W-1:0]       tlb_ps,
    input  logic [tlb_pkg::ASID_W-1:0]     tlb_asid,
    input  logic                           tlb_g,
    input  logic [tlb_pkg::PPN_W-1:0]      tlb_ppn0,
    input  logic [tlb_pkg::PLV_W-1:0]      tlb_plv0,
    input  logic                           tlb_d0,
    input  logic                           tlb_v0,
    input  logic [tlb_pkg::PPN_W-1:0]      tlb_ppn1,
    input  logic [tlb_pkg::PLV_W-1:0]      tlb_plv1,
    input  logic                           tlb_d1,
    input  logic                           tlb_v1,
    output logic                           resp_valid,
    output logic [addr_pkg::PA_W-1:0]      resp_pa,
    output logic [tlb_pkg::EX_W-1:0]       resp_ex
);
    localparam int IDX_W = $clog2(TLB_ENTRIES);

    tlb_write_if #(.IDX_W(IDX_W)) wr_if ();
    tlb_result_if                 tlb_res_if ();
    window_result_if              win_res_if ();

    assign wr_if.we    = tlb_we;
    assign wr_if.index = tlb_index;
    assign wr_if.e     = tlb_e;
    assign wr_if.vppn  = tlb_vppn;
    assign wr_if.ps    = tlb_ps;
    assign wr_if.asid  = tlb_asid;
    assign wr_if.g     = tlb_g;
    assign wr_if.ppn0  = tlb_ppn0;
    assign wr_if.plv0  = tlb_plv0;
    assign wr_if.d0    = tlb_d0;
    assign wr_if.v0    = tlb_v0;
    assign wr_if.ppn1  = tlb_ppn1;
    assign wr_if.plv1  = tlb_plv1;
    assign wr_if.d1    = tlb_d1;
    assign wr_if.v1    = tlb_v1;

    tlb_lookup #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_tlb (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_va   (req_va),
        .req_asid (req_asid),
        .wr       (wr_if),
        .res      (tlb_res_if)
    );

    // runs alongside the TLB on the same request
    window_map u_win (
        .clk    (clk),
        .rst_n  (rst_n),
        .req_va (req_va),
        .crmd   (crmd),
        .dmw0   (dmw0),
        .dmw1   (dmw1),
        .res    (win_res_if)
    );

    translate_select u_sel (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_kind   (req_kind),
        .crmd       (crmd),
        .tlb        (tlb_res_if),
        .win        (win_res_if),
        .resp_valid (resp_valid),
        .resp_pa    (resp_pa),
        .resp_ex    (resp_ex)
    );

endmodule

// File: rtl/tlb_lookup.sv
module tlb_lookup #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  addr_pkg::va_t              req_va,
    input  logic [tlb_pkg::ASID_W-1:0] req_asid,
    tlb_write_if.sink                  wr,
    tlb_result_if.source               res
);
    import addr_pkg::*;
    import tlb_pkg::*;

    localparam int IDX_W      = $clog2(TLB_ENTRIES);
    localparam int HUGE_SHIFT = PS_2M - PS_4K;    // low vppn bits ignored by 2 MB pages

    logic [TLB_ENTRIES-1:0] ent_e;
    logic [TLB_ENTRIES-1:0] ent_2m;
    logic [TLB_ENTRIES-1:0] ent_g;
    logic [TLB_ENTRIES-1:0] ent_d0;
    logic [TLB_ENTRIES-1:0] ent_v0;
    logic [TLB_ENTRIES-1:0] ent_d1;
    logic [TLB_ENTRIES-1:0] ent_v1;
    logic [VPPN_W-1:0]      ent_vppn [TLB_ENTRIES];
    logic [ASID_W-1:0]      ent_asid [TLB_ENTRIES];
    logic [PPN_W-1:0]       ent_ppn0 [TLB_ENTRIES];
    logic [PPN_W-1:0]       ent_ppn1 [TLB_ENTRIES];
    logic [PLV_W-1:0]       ent_plv0 [TLB_ENTRIES];
    logic [PLV_W-1:0]       ent_plv1 [TLB_ENTRIES];

    logic [TLB_ENTRIES-1:0] hit_vec;
    logic [IDX_W-1:0]       hit_idx;
    logic                   sel_odd;
    logic [PPN_W-1:0]       sel_ppn;
    logic [PA_W-1:0]        sel_pa;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_e <= '0;
        end else if (wr.we) begin
            ent_e[wr.index] <= wr.e;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.we) begin
            ent_2m[wr.index]   <= (wr.ps == PS_2M);    // anything else treated as 4 KB
            ent_g[wr.index]    <= wr.g;
            ent_vppn[wr.index] <= wr.vppn;
            ent_asid[wr.index] <= wr.asid;
            ent_ppn0[wr.index] <= wr.ppn0;
            ent_plv0[wr.index] <= wr.plv0;
            ent_d0[wr.index]   <= wr.d0;
            ent_v0[wr.index]   <= wr.v0;
            ent_ppn1[wr.index] <= wr.ppn1;
            ent_plv1[wr.index] <= wr.plv1;
            ent_d1[wr.index]   <= wr.d1;
            ent_v1[wr.index]   <= wr.v1;
        end
    end

    // parallel compare against every entry
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hit_vec[i] = ent_e[i]
                && (ent_g[i] || ent_asid[i] == req_asid)
                && (ent_2m[i]
                    ? ent_vppn[i][VPPN_W-1:HUGE_SHIFT] == req_va.page.vppn[VPPN_W-1:HUGE_SHIFT]
                    : ent_vppn[i] == req_va.page.vppn);
        end
    end

    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (hit_vec[i]) begin
                hit_idx = IDX_W'(i);    // multiple hits undefined
            end
        end
    end

    assign sel_odd = ent_2m[hit_idx] ? req_va.page.vppn[HUGE_SHIFT-1]    // va bit 21
                                     : req_va.page.odd;                  // va bit 12
    assign sel_ppn = sel_odd ? ent_ppn1[hit_idx] : ent_ppn0[hit_idx];

    // 2 MB keeps the top 11 ppn bits and a 21-bit offset
    assign sel_pa = ent_2m[hit_idx]
        ? {sel_ppn[PPN_W-1 -: PA_W-PS_2M], req_va.page.vppn[HUGE_SHIFT-2:0],
           req_va.page.odd, req_va.page.offset}
        : {sel_ppn, req_va.page.offset};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res.found <= 1'b0;
        end else begin
            res.found <= |hit_vec;
        end
    end

    always_ff @(posedge clk) begin
        res.pa  <= sel_pa;
        res.plv <= sel_odd ? ent_plv1[hit_idx] : ent_plv0[hit_idx];
        res.d   <= sel_odd ? ent_d1[hit_idx] : ent_d0[hit_idx];
        res.v   <= sel_odd ? ent_v1[hit_idx] : ent_v0[hit_idx];
    end

endmodule

// File: rtl/tlb_pkg.sv
package tlb_pkg;

    localparam int VPPN_W = 19;
    localparam int PPN_W  = 20;
    localparam int ASID_W = 10;
    localparam int PLV_W  = 2;
    localparam int PS_W   = 6;

    // supported page sizes, as log2 of the page bytes
    localparam int PS_4K = 12;
    localparam int PS_2M = 21;

    localparam int EX_W = 3;
    localparam logic [EX_W-1:0] EX_NONE = 3'd0;
    localparam logic [EX_W-1:0] EX_TLBR = 3'd1;    // refill with no entry
    localparam logic [EX_W-1:0] EX_PIF  = 3'd2;    // invalid page on fetch
    localparam logic [EX_W-1:0] EX_PIL  = 3'd3;    // invalid page on load
    localparam logic [EX_W-1:0] EX_PIS  = 3'd4;    // invalid page on store
    localparam logic [EX_W-1:0] EX_PPI  = 3'd5;    // privilege violation
    localparam logic [EX_W-1:0] EX_PME  = 3'd6;    // store to clean page

    localparam int KIND_W = 2;
    localparam logic [KIND_W-1:0] KIND_FETCH = 2'd0;
    localparam logic [KIND_W-1:0] KIND_LOAD  = 2'd1;
    localparam logic [KIND_W-1:0] KIND_STORE = 2'd2;

endpackage

// File: rtl/translate_select.sv
module translate_select (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req_valid,
    input  logic [tlb_pkg::KIND_W-1:0] req_kind,
    input  logic [addr_pkg::REG_W-1:0] crmd,
    tlb_result_if.sink                 tlb,
    window_result_if.sink              win,
    output logic                       resp_valid,
    output logic [addr_pkg::PA_W-1:0]  resp_pa,
    output logic [tlb_pkg::EX_W-1:0]   resp_ex
);
    import addr_pkg::*;
    import tlb_pkg::*;

    logic              valid_q;
    logic [KIND_W-1:0] kind_q;
    logic [PLV_W-1:0]  plv_q;
    logic [PA_W-1:0]   pa_d;
    logic [EX_W-1:0]   ex_d;

    // align request attributes with the lookup stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        kind_q <= req_kind;
        plv_q  <= crmd[CRMD_PLV_LO +: PLV_W];
    end

    // windows bypass the TLB checks entirely
    always_comb begin
        pa_d = win.hit ? win.pa : tlb.pa;
        if (win.hit) begin
            ex_d = EX_NONE;
        end else if (!tlb.found) begin
            ex_d = EX_TLBR;
        end else if (!tlb.v) begin
            case (kind_q)
                KIND_FETCH: ex_d = EX_PIF;
                KIND_LOAD:  ex_d = EX_PIL;
                default:    ex_d = EX_PIS;
            endcase
        end else if (plv_q > tlb.plv) begin
            ex_d = EX_PPI;                        // less privileged than page
        end else if (kind_q == KIND_STORE && !tlb.d) begin
            ex_d = EX_PME;
        end else begin
            ex_d = EX_NONE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= valid_q;
        end
    end

    always_ff @(posedge clk) begin
        resp_pa <= pa_d;
        resp_ex <= ex_d;
    end

endmodule

// File: rtl/window_map.sv
module window_map (
    input  logic                      clk,
    input  logic                      rst_n,
    input  addr_pkg::va_t             req_va,
    input  logic [addr_pkg::REG_W-1:0] crmd,
    input  logic [addr_pkg::REG_W-1:0] dmw0,
    input  logic [addr_pkg::REG_W-1:0] dmw1,
    window_result_if.source           res
);
    import addr_pkg::*;
    import tlb_pkg::*;

    logic [PLV_W-1:0] plv;
    logic             direct;
    logic             hit0;
    logic             hit1;
    logic [PA_W-1:0]  next_pa;

    // window enabled for this level and segment matches
    function automatic logic dmw_match(input logic [REG_W-1:0] dmw,
                                       input logic [PLV_W-1:0] lvl,
                                       input logic [SEG_W-1:0] vseg);
        logic en;
        en = (lvl == PLV_W'(0) && dmw[DMW_PLV0_BIT])
          || (lvl == PLV_W'(3) && dmw[DMW_PLV3_BIT]);
        return en && dmw[DMW_VSEG_LO +: SEG_W] == vseg;
    endfunction

    assign plv    = crmd[CRMD_PLV_LO +: PLV_W];
    assign direct = crmd[CRMD_DA_BIT] && !crmd[CRMD_PG_BIT];    // da=1 pg=0
    assign hit0   = dmw_match(dmw0, plv, req_va.win.vseg);
    assign hit1   = dmw_match(dmw1, plv, req_va.win.vseg);

    always_comb begin
        if (direct) begin
            next_pa = req_va;                                      // pa equals va
        end else if (hit0) begin
            next_pa = {dmw0[DMW_PSEG_LO +: SEG_W], req_va.win.rest};    // dmw0 wins
        end else begin
            next_pa = {dmw1[DMW_PSEG_LO +: SEG_W], req_va.win.rest};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res.hit <= 1'b0;
        end else begin
            res.hit <= direct || hit0 || hit1;
        end
    end

    always_ff @(posedge clk) begin
        res.pa <= next_pa;
    end

endmodule

// File: run.sh
#!/bin/sh
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_mmu \
    -f verilog.f -o sim_mmu \
    && ./obj_dir/sim_mmu 2>&1 | tee /dev/stderr | grep -q "Done: no errors" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: tb/tb_mmu.sv
module tb_mmu;
    timeunit 1ns;
    timeprecision 1ps;

    import addr_pkg::*;
    import tlb_pkg::*;

    localparam int ENTRIES = 16;
    localparam int IDX_W   = $clog2(ENTRIES);

    logic              clk = 1'b0;
    logic              rst_n;
    logic              req_valid;
    logic [VA_W-1:0]   req_va;
    logic [KIND_W-1:0] req_kind;
    logic [ASID_W-1:0] req_asid;
    logic [REG_W-1:0]  crmd;
    logic [REG_W-1:0]  dmw0;
    logic [REG_W-1:0]  dmw1;
    logic              tlb_we;
    logic [IDX_W-1:0]  tlb_index;
    logic              tlb_e;
    logic [VPPN_W-1:0] tlb_vppn;
    logic [PS_W-1:0]   tlb_ps;
    logic [ASID_W-1:0] tlb_asid;
    logic              tlb_g;
    logic [PPN_W-1:0]  tlb_ppn0;
    logic [PLV_W-1:0]  tlb_plv0;
    logic              tlb_d0;
    logic              tlb_v0;
    logic [PPN_W-1:0]  tlb_ppn1;
    logic [PLV_W-1:0]  tlb_plv1;
    logic              tlb_d1;
    logic              tlb_v1;
    logic              resp_valid;
    logic [PA_W-1:0]   resp_pa;
    logic [EX_W-1:0]   resp_ex;

    // model copy of the TLB indexed by entry and odd page
    logic              m_e    [ENTRIES];
    logic              m_huge [ENTRIES];
    logic              m_g    [ENTRIES];
    logic [VPPN_W-1:0] m_vppn [ENTRIES];
    logic [ASID_W-1:0] m_asid [ENTRIES];
    logic [PPN_W-1:0]  m_ppn  [ENTRIES][2];
    logic [PLV_W-1:0]  m_plv  [ENTRIES][2];
    logic              m_d    [ENTRIES][2];
    logic              m_v    [ENTRIES][2];

    logic [EX_W+PA_W-1:0] exp_q[$];    // {ex, pa} per request
    int                   due_q[$];    // cycle the response must show up
    integer               seed = 58657;
    int                   cyc = 0;
    int                   wait_cycles;

    always #50 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    mmu_top #(
        .TLB_ENTRIES(ENTRIES)
    ) u_dut (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_va(req_va), .req_kind(req_kind),
        .req_asid(req_asid), .crmd(crmd), .dmw0(dmw0), .dmw1(dmw1),
        .tlb_we(tlb_we), .tlb_index(tlb_index), .tlb_e(tlb_e), .tlb_vppn(tlb_vppn),
        .tlb_ps(tlb_ps), .tlb_asid(tlb_asid), .tlb_g(tlb_g),
        .tlb_ppn0(tlb_ppn0), .tlb_plv0(tlb_plv0), .tlb_d0(tlb_d0), .tlb_v0(tlb_v0),
        .tlb_ppn1(tlb_ppn1), .tlb_plv1(tlb_plv1), .tlb_d1(tlb_d1), .tlb_v1(tlb_v1),
        .resp_valid(resp_valid), .resp_pa(resp_pa), .resp_ex(resp_ex)
    );

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_ex(input logic [EX_W-1:0] got, input logic [EX_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: exception code %0d, expected %0d", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pa(input logic [PA_W-1:0] got, input logic [PA_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: physical address %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    function automatic logic window_on(input logic [REG_W-1:0] w,
                                       input logic [PLV_W-1:0] lvl,
                                       input logic [VA_W-1:0]  va);
        return w[31:29] == va[31:29]
            && ((lvl == 2'd0 && w[DMW_PLV0_BIT]) || (lvl == 2'd3 && w[DMW_PLV3_BIT]));
    endfunction

    // expected {ex, pa} for one request against the model state
    function automatic logic [EX_W+PA_W-1:0] ref_translate(
            input logic [VA_W-1:0] va, input logic [KIND_W-1:0] kind,
            input logic [ASID_W-1:0] asid, input logic [REG_W-1:0] mode,
            input logic [REG_W-1:0] w0, input logic [REG_W-1:0] w1);
        logic [PLV_W-1:0] lvl;
        int               hit;
        logic             odd;
        logic [PA_W-1:0]  pa;
        lvl = mode[CRMD_PLV_LO +: PLV_W];
        if (mode[CRMD_DA_BIT] && !mode[CRMD_PG_BIT]) return {EX_NONE, va};
        if (window_on(w0, lvl, va)) return {EX_NONE, w0[27:25], va[28:0]};
        if (window_on(w1, lvl, va)) return {EX_NONE, w1[27:25], va[28:0]};
        hit = -1;
        for (int i = 0; i < ENTRIES; i++) begin
            if (m_e[i] && (m_g[i] || m_asid[i] == asid) && m_vppn[i][18:9] == va[31:22]
                && (m_huge[i] || m_vppn[i][8:0] == va[21:13])) begin
                hit = i;
            end
        end
        if (hit < 0) return {EX_TLBR, PA_W'(0)};
        odd = m_huge[hit] ? va[21] : va[12];
        pa  = m_huge[hit] ? {m_ppn[hit][odd][19:9], va[20:0]} : {m_ppn[hit][odd], va[11:0]};
        if (!m_v[hit][odd]) begin
            if (kind == KIND_FETCH) return {EX_PIF, pa};
            if (kind == KIND_LOAD) return {EX_PIL, pa};
            return {EX_PIS, pa};
        end
        if (lvl > m_plv[hit][odd]) return {EX_PPI, pa};
        if (kind == KIND_STORE && !m_d[hit][odd]) return {EX_PME, pa};
        return {EX_NONE, pa};
    endfunction

    // one cycle of stimulus with maybe a request and maybe a TLB write
    task automatic drive_cycle(input bit paged, input int write_odds);
        int              idx;
        logic [VA_W-1:0] va;
        @(posedge clk);
        #5;
        crmd = '0;
        crmd[paged ? CRMD_PG_BIT : CRMD_DA_BIT] = 1'b1;
        crmd[CRMD_PLV_LO +: PLV_W] = PLV_W'($random(seed));
        dmw0 = $random(seed) & 32'hEE00_0009;    // vseg, pseg, level 0/3 enables
        dmw1 = $random(seed) & 32'hEE00_0009;
        req_valid = ($random(seed) & 7) != 0;
        req_kind  = KIND_W'({$random(seed)} % 3);
        idx = {$random(seed)} % ENTRIES;
        va  = $random(seed);
        case ($random(seed) & 3)
            0: va[31:29] = dmw0[31:29];
            1: va[31:29] = dmw1[31:29];
            default: begin
                va[31:22] = m_vppn[idx][18:9];    // aim at a TLB entry
                if (!m_huge[idx]) va[21:13] = m_vppn[idx][8:0];
            end
        endcase
        req_va   = va;
        req_asid = (($random(seed) & 3) == 0) ? ASID_W'($random(seed) & 3) : m_asid[idx];
        if (req_valid) begin
            exp_q.push_back(ref_translate(va, req_kind, req_asid, crmd, dmw0, dmw1));
            due_q.push_back(cyc + 2);
        end
        // the write lands at the next edge after this request is sampled
        tlb_we = ({$random(seed)} % 8) < write_odds;
        if (tlb_we) begin
            tlb_index = IDX_W'($random(seed));
            tlb_e     = ($random(seed) & 7) != 0;
            tlb_ps    = ($random(seed) & 1) ? PS_W'(PS_2M) : PS_W'(PS_4K);
            tlb_vppn  = {6'h15, tlb_index, 9'($random(seed))};    // unique per index
            tlb_asid  = ASID_W'($random(seed) & 3);
            tlb_g     = ($random(seed) & 3) == 0;
            {tlb_ppn0, tlb_plv0, tlb_d0, tlb_v0} = 24'($random(seed));
            {tlb_ppn1, tlb_plv1, tlb_d1, tlb_v1} = 24'($random(seed));
            m_e[tlb_index]    = tlb_e;
            m_huge[tlb_index] = (tlb_ps == PS_W'(PS_2M));
            m_g[tlb_index]    = tlb_g;
            m_vppn[tlb_index] = tlb_vppn;
            m_asid[tlb_index] = tlb_asid;
            m_ppn[tlb_index][0] = tlb_ppn0;
            m_plv[tlb_index][0] = tlb_plv0;
            m_d[tlb_index][0]   = tlb_d0;
            m_v[tlb_index][0]   = tlb_v0;
            m_ppn[tlb_index][1] = tlb_ppn1;
            m_plv[tlb_index][1] = tlb_plv1;
            m_d[tlb_index][1]   = tlb_d1;
            m_v[tlb_index][1]   = tlb_v1;
        end
    endtask

    always @(negedge clk) begin : compare_resp
        logic [EX_W+PA_W-1:0] exp;
        int                   due;
        if (rst_n && resp_valid) begin
            if (exp_q.size() == 0) begin
                $display("response at %0d ns with no request outstanding", $time);
                abort_run();
            end else begin
                exp = exp_q.pop_front();
                due = due_q.pop_front();
                if (cyc != due) begin
                    $display("[ERROR] %0d ns: response in cycle %0d, expected cycle %0d",
                             $time, cyc, due);
                    abort_run();
                end
                check_ex(resp_ex, exp[PA_W +: EX_W]);
                if (exp[PA_W +: EX_W] == EX_NONE) check_pa(resp_pa, exp[PA_W-1:0]);
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_va = '0;
        req_kind = '0;
        req_asid = '0;
        crmd = '0;
        dmw0 = '0;
        dmw1 = '0;
        tlb_we = 1'b0;
        tlb_index = '0;
        tlb_e = 1'b0;
        tlb_vppn = '0;
        tlb_ps = '0;
        tlb_asid = '0;
        tlb_g = 1'b0;
        {tlb_ppn0, tlb_plv0, tlb_d0, tlb_v0} = '0;
        {tlb_ppn1, tlb_plv1, tlb_d1, tlb_v1} = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            m_e[i] = 1'b0;    // reset clears all enables
            m_huge[i] = 1'b0;
            m_g[i] = 1'b0;
            m_vppn[i] = '0;
            m_asid[i] = '0;
            for (int j = 0; j < 2; j++) begin
                m_ppn[i][j] = '0;
                m_plv[i][j] = '0;
                m_d[i][j] = 1'b0;
                m_v[i][j] = 1'b0;
            end
        end
        repeat (10) @(posedge clk);
        #5 rst_n = 1'b1;
        repeat (60) drive_cycle(1'b0, 4);     // direct mode while the table fills
        repeat (800) drive_cycle(1'b1, 2);    // paged mode with windows and TLB mixed with writes
        @(posedge clk);
        #5;
        req_valid = 1'b0;
        tlb_we = 1'b0;
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < 20) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d responses never arrived", exp_q.size());
            abort_run();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// File: verilog.f
rtl/addr_pkg.sv
rtl/tlb_pkg.sv
rtl/mmu_ifs.sv
rtl/tlb_lookup.sv
rtl/window_map.sv
rtl/translate_select.sv
rtl/mmu_top.sv
tb/tb_mmu.sv
